//--- hw/rtg_pkg.sv
/*
  Shared widths, encodings and bundles for the RTG display mixer.
  Sync bits are active low, as driven by the chipset.
  rtg_cfg_t is expected to change only while the picture is blanked.
*/
package rtg_pkg;

  //////////////////////////////
  // Widths and sizes
  //////////////////////////////
  localparam int colour_w      = 8;   // Bits per colour channel
  localparam int osd_dim_shift = 2;   // Low bits dropped under the OSD
  localparam int clut_depth    = 256; // Palette entries
  localparam int clut_idx_w    = 8;   // Palette index width
  localparam int pix_w_w       = 4;   // Fetch period field
  localparam int vb_end_w      = 7;   // Extra vblank lines field
  localparam int word_w        = 16;  // Fetched pixel word

  // OSD colour above the dimmed picture
  localparam logic [osd_dim_shift-1:0] osd_fg      = 2'b11; // Text pixel, all channels
  localparam logic [osd_dim_shift-1:0] osd_bg_rg   = 2'b00; // Background red and green
  localparam logic [osd_dim_shift-1:0] osd_bg_blue = 2'b10; // Bluish background tint

  //////////////////////////////
  // Bundles
  //////////////////////////////
  typedef struct packed {
    logic [colour_w-1:0] red;
    logic [colour_w-1:0] green;
    logic [colour_w-1:0] blue;
  } rgb_t;                          // 24 bits

  typedef struct packed {
    logic hs;                       // Active low
    logic vs;                       // Active low
    logic cs;                       // Active low
  } sync_t;

  typedef struct packed {
    rgb_t  rgb;
    sync_t sync;
  } native_vid_t;                   // Chipset picture, 27 bits

  typedef struct packed {
    logic                ena;       // RTG screen on
    logic                clut_mode; // 8-bit palette mode
    logic                ext;       // One fetch past the blank edge
    logic [pix_w_w-1:0]  pix_width; // Clocks per fetch minus 1
    logic [vb_end_w-1:0] vb_end;    // Extra blanked lines
  } rtg_cfg_t;                      // 14 bits

  typedef struct packed {
    logic                  we;      // Write this clock
    logic [clut_idx_w-1:0] idx;
    rgb_t                  rgb;
  } clut_wr_t;                      // 33 bits

  //////////////////////////////
  // Encodings
  //////////////////////////////
  typedef enum logic [1:0] {
    SRC_NATIVE   = 2'd0,            // Chipset colour
    SRC_HICOLOUR = 2'd1,            // 15-bit RTG expanded
    SRC_CLUT     = 2'd2             // RTG palette lookup
  } vid_src_e;

  typedef enum logic [1:0] {
    VB_ACTIVE  = 2'd0,              // RTG picture visible
    VB_CHIPSET = 2'd1,              // Chipset vblank high
    VB_EXTEND  = 2'd2               // Counting extra lines
  } vblank_state_e;

endpackage

//--- hw/rtg_fetch_timer.sv
/*
  Pixel fetch pacing. pixel_req is combinational and has no back-pressure,
  so the word source must be ready on the edge after every request.
  pix_width should only change while blank is high.
*/
`timescale 1ns/1ps

module rtg_fetch_timer (
  input  logic              clk_114,
  input  logic              rst_n,
  input  rtg_pkg::rtg_cfg_t cfg,
  input  logic              rtg_vblank, // Extended vertical blank
  input  logic              hblank,     // Chipset horizontal blank
  output logic              pixel_req,  // One clock per fetched word
  output logic              blank_d,    // Blank one clock late
  output logic              lo_half     // CLUT byte select toward the path
);
  import rtg_pkg::*;

  logic               blank;
  logic               edge_fetch;
  logic [pix_w_w-1:0] cnt;       // Clocks since last request
  logic [pix_w_w-1:0] mid_cnt;
  logic               half_sel;  // Second byte of the word is due

  //////////////////////////////
  // Request strobe
  //////////////////////////////
  assign blank      = rtg_vblank | hblank;
  assign edge_fetch = blank & ~blank_d & cfg.ext; // First blank clock only
  assign mid_cnt    = cfg.pix_width >> 1;         // Floor of half period

  assign pixel_req = cfg.ena & (~blank | edge_fetch) & (cnt == cfg.pix_width);

  //////////////////////////////
  // Counter and half select
  //////////////////////////////
  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      cnt      <= '0;
      blank_d  <= 1'b1;         // Comes out of reset blanked
      half_sel <= 1'b0;
      lo_half  <= 1'b0;
    end else begin
      blank_d <= blank;
      lo_half <= half_sel;      // Lines up with the stage 1 palette read
      if (blank || pixel_req) begin
        cnt      <= '0;         // Restart period
        half_sel <= 1'b0;       // Back to high byte
      end else begin
        cnt <= cnt + 1'b1;
        if (cnt == mid_cnt)
          half_sel <= 1'b1;     // Low byte for the rest of the period
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  // Requests keep the count bounded once RTG is enabled
  a_cnt_bound : assert property (@(posedge clk_114) disable iff (!rst_n)
    cfg.ena |-> (cnt <= cfg.pix_width))
    else $error("fetch counter passed pix_width");

  // Blank restarts the count, so only a one-clock period requests right after it
  a_req_after_blank : assert property (@(posedge clk_114) disable iff (!rst_n)
    (pixel_req && blank_d) |-> (cfg.pix_width == '0))
    else $error("pixel_req right after blank with pix_width above 0");

endmodule

//--- hw/rtg_vblank_extend.sv
/*
  Holds the RTG picture blanked for vb_end lines after chipset vblank.
  hs is sampled on clk_114 and only its rising edges are counted,
  so it needs no synchroniser beyond the single sample register.
*/
`timescale 1ns/1ps

module rtg_vblank_extend (
  input  logic                         clk_114,
  input  logic                         rst_n,
  input  logic                         vblank,     // Chipset vertical blank
  input  logic                         hs,         // Chipset hsync, active low
  input  logic [rtg_pkg::vb_end_w-1:0] vb_end,     // Extra lines to blank
  output logic                         rtg_vblank
);
  import rtg_pkg::*;

  vblank_state_e       state;
  logic [vb_end_w-1:0] line_cnt;  // Lines seen since vblank fell
  logic                hs_d;
  logic                hs_rise;

  assign hs_rise    = hs & ~hs_d;            // End of sync pulse
  assign rtg_vblank = (state != VB_ACTIVE);  // Straight from state register

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      state    <= VB_CHIPSET;
      line_cnt <= '0;
      hs_d     <= 1'b1;                      // Sync idle
    end else begin
      hs_d <= hs;
      if (vblank) begin
        state    <= VB_CHIPSET;
        line_cnt <= '0;
      end else if (state != VB_ACTIVE) begin
        if (line_cnt == vb_end) begin
          state <= VB_ACTIVE;                // Drop blank next clock
        end else begin
          state <= VB_EXTEND;
          if (hs_rise)
            line_cnt <= line_cnt + 1'b1;
        end
      end
    end
  end

  // Count stops at vb_end and leaves EXTEND on the next clock
  a_cnt_limit : assert property (@(posedge clk_114) disable iff (!rst_n)
    (state == VB_EXTEND) |-> (line_cnt <= vb_end))
    else $error("vblank line count passed vb_end");

endmodule

//--- hw/rtg_clut.sv
/*
  256 x 24 palette RAM. One write port, one registered read port.
  Read data appears one clock after rd_idx. Contents are undefined
  until written, and a read of the entry being written returns old data.
*/
`timescale 1ns/1ps

module rtg_clut (
  input  logic                           clk_114,
  input  rtg_pkg::clut_wr_t              clut_wr, // Write strobe with index and colour
  input  logic [rtg_pkg::clut_idx_w-1:0] rd_idx,
  output rtg_pkg::rgb_t                  rd_rgb
);
  import rtg_pkg::*;

  rgb_t mem [clut_depth];      // Palette storage

  //////////////////////////////
  // Write port
  //////////////////////////////
  always_ff @(posedge clk_114) begin
    if (clut_wr.we)
      mem[clut_wr.idx] <= clut_wr.rgb;
  end

  //////////////////////////////
  // Read port
  //////////////////////////////
  always_ff @(posedge clk_114) begin
    rd_rgb <= mem[rd_idx];     // One clock latency
  end

endmodule

//--- hw/rtg_pixel_path.sv
/*
  Two-stage colour pipeline. Stage 1 tags the source, expands 15-bit
  colour and issues the palette read. Stage 2 picks the colour, applies
  the OSD overlay and registers vid_out. Latency is 2 clocks throughout.
*/
`timescale 1ns/1ps

module rtg_pixel_path (
  input  logic                           clk_114,
  input  logic                           rst_n,
  input  rtg_pkg::rtg_cfg_t              cfg,
  input  rtg_pkg::native_vid_t           native,     // Chipset picture
  input  logic [rtg_pkg::word_w-1:0]     pixel_word, // Held by the source
  input  logic                           lo_half,    // Low byte as palette index
  input  logic                           blank_d,    // Blank one clock late
  input  logic                           osd_window,
  input  logic                           osd_pixel,
  input  rtg_pkg::rgb_t                  clut_rgb,   // Palette data, one clock late
  output logic [rtg_pkg::clut_idx_w-1:0] clut_idx,
  output rtg_pkg::native_vid_t           vid_out
);
  import rtg_pkg::*;

  vid_src_e    src_nxt;
  vid_src_e    src_s1;      // Source tag, blank now 2 clocks old
  native_vid_t nat_s1;
  rgb_t        hic_exp;
  rgb_t        hic_s1;
  logic        osd_win_s1;
  logic        osd_pix_s1;
  rgb_t        pick;        // Colour before OSD
  logic [osd_dim_shift-1:0] osd_r;
  logic [osd_dim_shift-1:0] osd_g;
  logic [osd_dim_shift-1:0] osd_b;

  // OSD value on top, picture dimmed underneath
  function automatic logic [colour_w-1:0] osd_mix(
    input logic [osd_dim_shift-1:0] osd,
    input logic [colour_w-1:0]      chan
  );
    return {osd, chan[colour_w-1:osd_dim_shift]};
  endfunction

  //////////////////////////////
  // Stage 1
  //////////////////////////////
  // Each 5-bit field padded with its own top 3 bits
  assign hic_exp.red   = {pixel_word[14:10], pixel_word[14:12]};
  assign hic_exp.green = {pixel_word[9:5],   pixel_word[9:7]};
  assign hic_exp.blue  = {pixel_word[4:0],   pixel_word[4:2]};

  assign clut_idx = lo_half ? pixel_word[7:0] : pixel_word[15:8];

  always_comb begin
    if (!cfg.ena || blank_d)
      src_nxt = SRC_NATIVE;
    else if (cfg.clut_mode)
      src_nxt = SRC_CLUT;
    else
      src_nxt = SRC_HICOLOUR;
  end

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      src_s1          <= SRC_NATIVE;
      nat_s1.rgb      <= '0;
      nat_s1.sync     <= '1;     // Sync inactive
      osd_win_s1      <= 1'b0;
      osd_pix_s1      <= 1'b0;
    end else begin
      src_s1     <= src_nxt;
      nat_s1     <= native;
      osd_win_s1 <= osd_window;
      osd_pix_s1 <= osd_pixel;
    end
  end

  always_ff @(posedge clk_114) begin
    hic_s1 <= hic_exp;           // Only read when tagged hi-colour
  end

  //////////////////////////////
  // Stage 2
  //////////////////////////////
  always_comb begin
    case (src_s1)
      SRC_CLUT:     pick = clut_rgb;
      SRC_HICOLOUR: pick = hic_s1;
      default:      pick = nat_s1.rgb;
    endcase
  end

  assign osd_r = osd_pix_s1 ? osd_fg : osd_bg_rg;
  assign osd_g = osd_pix_s1 ? osd_fg : osd_bg_rg;
  assign osd_b = osd_pix_s1 ? osd_fg : osd_bg_blue;

  always_ff @(posedge clk_114 or negedge rst_n) begin
    if (!rst_n) begin
      vid_out.rgb  <= '0;
      vid_out.sync <= '1;
    end else begin
      vid_out.sync <= nat_s1.sync;
      if (osd_win_s1) begin
        vid_out.rgb.red   <= osd_mix(osd_r, pick.red);
        vid_out.rgb.green <= osd_mix(osd_g, pick.green);
        vid_out.rgb.blue  <= osd_mix(osd_b, pick.blue);
      end else begin
        vid_out.rgb <= pick;
      end
    end
  end

  // Palette mode must still be set when a palette pixel reaches stage 2
  a_clut_tag : assert property (@(posedge clk_114) disable iff (!rst_n)
    (src_s1 == SRC_CLUT) |-> cfg.clut_mode)
    else $error("SRC_CLUT tag without clut_mode");

endmodule

//--- hw/rtg_video_top.sv
/*
  RTG display mixer, single clk_114 domain.
  The pixel source must hold a word ready at all times and present the
  next one before the rising edge after each pixel_req.
  vid_out follows its inputs by exactly 2 clocks.
*/
`timescale 1ns/1ps

module rtg_video_top (
  input  logic                       clk_114,
  input  logic                       rst_n,
  input  rtg_pkg::rtg_cfg_t          cfg,        // Quasi-static setup
  input  rtg_pkg::native_vid_t       native,     // Chipset picture and sync
  input  logic                       hblank,
  input  logic                       vblank,
  input  logic                       osd_window,
  input  logic                       osd_pixel,
  input  rtg_pkg::clut_wr_t          clut_wr,    // Palette write strobe
  input  logic [rtg_pkg::word_w-1:0] pixel_word, // Current fetched word
  output logic                       pixel_req,  // Advance to next word
  output rtg_pkg::native_vid_t       vid_out
);
  import rtg_pkg::*;

  logic                  rtg_vblank;  // Vblank plus extra lines
  logic                  blank_d;
  logic                  lo_half;
  logic [clut_idx_w-1:0] clut_idx;
  rgb_t                  clut_rgb;

  //////////////////////////////
  // Timing
  //////////////////////////////
  rtg_vblank_extend u_vblank (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .vblank     (vblank),
    .hs         (native.sync.hs),  // Counts line ends
    .vb_end     (cfg.vb_end),
    .rtg_vblank (rtg_vblank)
  );

  rtg_fetch_timer u_fetch (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .rtg_vblank (rtg_vblank),
    .hblank     (hblank),
    .pixel_req  (pixel_req),
    .blank_d    (blank_d),
    .lo_half    (lo_half)
  );

  //////////////////////////////
  // Colour
  //////////////////////////////
  rtg_clut u_clut (
    .clk_114    (clk_114),
    .clut_wr    (clut_wr),
    .rd_idx     (clut_idx),
    .rd_rgb     (clut_rgb)         // Arrives in stage 2
  );

  rtg_pixel_path u_path (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .native     (native),
    .pixel_word (pixel_word),
    .lo_half    (lo_half),
    .blank_d    (blank_d),
    .osd_window (osd_window),
    .osd_pixel  (osd_pixel),
    .clut_rgb   (clut_rgb),
    .clut_idx   (clut_idx),
    .vid_out    (vid_out)
  );

endmodule

//--- testbench/tb_rtg_video.sv
/*
  Testbench for rtg_video_top. Line timing is 64 active and 16 blank clocks.
  Vblank covers 4 lines of every 40. Colours and words are random from a fixed seed.
  The first 256 clocks fill the whole palette, so later CLUT reads are defined.
  RTG is off in frames 0 and 4. pix_width and vb_end change per frame.
*/
`timescale 1ns/1ps

module tb_rtg_video;
  import rtg_pkg::*;

  localparam int     line_len    = 80;            // Clocks per line
  localparam int     active_len  = 64;
  localparam int     frame_lines = 40;
  localparam int     vb_lines    = 4;             // Chipset vblank lines
  localparam int     frame_len   = line_len * frame_lines;
  localparam int     n_frames    = 8;
  localparam int     run_cycles  = n_frames * frame_len;
  localparam longint timeout_ns  = longint'(run_cycles) * 40 * 2;

  logic                clk_114;
  logic                rst_n;
  rtg_cfg_t            cfg;
  native_vid_t         native;
  logic                hblank;
  logic                vblank;
  logic                osd_window;
  logic                osd_pixel;
  clut_wr_t            clut_wr;
  logic [word_w-1:0]   pixel_word;       // Model FIFO head
  logic                pixel_req;
  native_vid_t         vid_out;

  // Reference model state
  logic [pix_w_w-1:0]  m_cnt;
  logic                m_blank_d;
  logic                m_half;
  logic                m_lo_half;
  logic                m_vb_active;      // Extended vblank over
  logic [vb_end_w-1:0] m_line;
  logic                m_hs_d;
  rgb_t                m_pal [clut_depth];
  vid_src_e            m_src1;
  native_vid_t         m_nat1;
  rgb_t                m_hic1;
  rgb_t                m_clut_q;         // Palette read register
  logic                m_osdw1;
  logic                m_osdp1;
  native_vid_t         m_vid;            // Expected vid_out

  integer seed;
  int     cyc;
  int     last_req;                      // Last request or blank clock
  logic   req_seen;
  int     err_vid;
  int     err_req;
  int     err_cad;
  int     err_other;
  int     req_count;
  int     hic_count;
  int     clut_count;

  rtg_video_top dut0 (
    .clk_114    (clk_114),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .native     (native),
    .hblank     (hblank),
    .vblank     (vblank),
    .osd_window (osd_window),
    .osd_pixel  (osd_pixel),
    .clut_wr    (clut_wr),
    .pixel_word (pixel_word),
    .pixel_req  (pixel_req),
    .vid_out    (vid_out)
  );

  initial begin
    clk_114 = 1'b0;
    forever #20 clk_114 = ~clk_114;     // 40 ns period
  end

  //////////////////////////////
  // Model
  //////////////////////////////
  function automatic rgb_t expand_hicolour(input logic [word_w-1:0] w);
    rgb_t c;
    c.red   = {w[14:10], w[14:12]};     // Field then its top 3 bits
    c.green = {w[9:5], w[9:7]};
    c.blue  = {w[4:0], w[4:2]};
    return c;
  endfunction

  function automatic rgb_t apply_osd(input rgb_t c, input logic pix);
    rgb_t o;
    o.red   = {pix ? 2'b11 : 2'b00, c.red[7:2]};
    o.green = {pix ? 2'b11 : 2'b00, c.green[7:2]};
    o.blue  = {pix ? 2'b11 : 2'b10, c.blue[7:2]};   // Blue tint behind text
    return o;
  endfunction

  function automatic logic model_blank();
    return !m_vb_active || hblank;
  endfunction

  function automatic logic predict_req();
    return cfg.ena && (!model_blank() || (!m_blank_d && cfg.ext))
           && (m_cnt == cfg.pix_width);
  endfunction

  task automatic reset_model();
    m_cnt       = '0;
    m_blank_d   = 1'b1;
    m_half      = 1'b0;
    m_lo_half   = 1'b0;
    m_vb_active = 1'b0;
    m_line      = '0;
    m_hs_d      = 1'b1;
    m_src1      = SRC_NATIVE;
    m_nat1.rgb  = '0;
    m_nat1.sync = '1;
    m_osdw1     = 1'b0;
    m_osdp1     = 1'b0;
    m_vid.rgb   = '0;
    m_vid.sync  = '1;                   // Sync idle out of reset
  endtask

  // One rising edge, inputs as driven on the falling edge before it
  task automatic step_model();
    logic blank;
    logic req;
    logic hs_rise;
    rgb_t pick;
    blank = model_blank();
    req   = predict_req();
    if (m_src1 == SRC_CLUT) begin
      pick = m_clut_q;
      clut_count++;
    end else if (m_src1 == SRC_HICOLOUR) begin
      pick = m_hic1;
      hic_count++;
    end else begin
      pick = m_nat1.rgb;
    end
    m_vid.sync = m_nat1.sync;
    m_vid.rgb  = m_osdw1 ? apply_osd(pick, m_osdp1) : pick;
    if (cfg.ena && !m_blank_d)          // Blank 2 clocks old at stage 2
      m_src1 = cfg.clut_mode ? SRC_CLUT : SRC_HICOLOUR;
    else
      m_src1 = SRC_NATIVE;
    m_nat1   = native;
    m_hic1   = expand_hicolour(pixel_word);
    m_osdw1  = osd_window;
    m_osdp1  = osd_pixel;
    m_clut_q = m_pal[m_lo_half ? pixel_word[7:0] : pixel_word[15:8]]; // Old data on collision
    if (clut_wr.we)
      m_pal[clut_wr.idx] = clut_wr.rgb;
    m_lo_half = m_half;
    m_blank_d = blank;
    if (blank || req) begin
      m_cnt  = '0;
      m_half = 1'b0;
    end else begin
      if (m_cnt == (cfg.pix_width >> 1))
        m_half = 1'b1;                  // Low byte from next clock
      m_cnt = m_cnt + 1'b1;
    end
    hs_rise = native.sync.hs && !m_hs_d;
    m_hs_d  = native.sync.hs;
    if (vblank) begin
      m_vb_active = 1'b0;
      m_line      = '0;
    end else if (!m_vb_active) begin
      if (m_line == cfg.vb_end)
        m_vb_active = 1'b1;
      else if (hs_rise)
        m_line = m_line + 1'b1;
    end
  endtask

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////
  task automatic drive_inputs();
    int          pos;
    int          row;
    int          col;
    int          frame;
    logic [31:0] r;
    logic [31:0] r2;
    pos   = cyc % frame_len;
    row   = pos / line_len;
    col   = pos % line_len;
    frame = cyc / frame_len;
    if (pos == 0) begin                 // New setup inside vblank
      r = $random(seed);
      cfg.ena       = (frame != 0) && (frame != 4);
      cfg.clut_mode = frame[0];
      cfg.ext       = frame[1];
      cfg.pix_width = r[3:0];
      cfg.vb_end    = {3'b000, r[7:4]}; // Up to 15 so the OSD rows meet RTG
    end
    hblank         = (col >= active_len);
    vblank         = (row < vb_lines);
    native.sync.hs = !(col >= 68 && col < 76);
    native.sync.vs = !vblank;
    native.sync.cs = native.sync.hs && native.sync.vs;
    r = $random(seed);
    native.rgb = r[23:0];
    osd_pixel  = r[24];
    osd_window = (row >= 10) && (row < 20) && (col >= 8) && (col < 40);
    r  = $random(seed);
    r2 = $random(seed);
    clut_wr.we  = (cyc < clut_depth) || (r[2:0] == 3'd0);
    clut_wr.idx = (cyc < clut_depth) ? 8'(cyc) : r[15:8];
    clut_wr.rgb = r2[23:0];
    if (req_seen) begin                 // Pop the FIFO after a request
      r = $random(seed);
      pixel_word = r[15:0];
    end
  endtask

  task automatic check_request();
    logic want;
    want     = predict_req();
    req_seen = pixel_req;
    if (pixel_req !== want) begin
      err_req++;
      $display("ERR %0t: pixel_req is %b, model expects %b", $time, pixel_req, want);
    end
    if (model_blank()) begin
      if (pixel_req === 1'b1 && (!cfg.ext || m_blank_d)) begin
        err_cad++;
        $display("ERR %0t: pixel_req inside blank without edge extension", $time);
      end
      last_req = cyc;                   // Gap restarts at blank
    end else if (pixel_req === 1'b1) begin
      req_count++;
      if (cyc - last_req != int'(cfg.pix_width) + 1) begin
        err_cad++;
        $display("ERR %0t: request gap %0d, expected %0d", $time,
                 cyc - last_req, int'(cfg.pix_width) + 1);
      end
      last_req = cyc;
    end
  endtask

  task automatic check_video();
    if (vid_out !== m_vid) begin
      err_vid++;
      $display("ERR %0t: vid_out %h, model expects %h", $time, vid_out, m_vid);
    end
  endtask

  initial begin
    seed       = 32'h6d05ecba;
    err_vid    = 0;
    err_req    = 0;
    err_cad    = 0;
    err_other  = 0;
    req_count  = 0;
    hic_count  = 0;
    clut_count = 0;
    last_req   = 0;
    req_seen   = 1'b0;
    cfg        = '0;
    native.rgb  = '0;
    native.sync = '1;
    hblank     = 1'b1;
    vblank     = 1'b1;
    osd_window = 1'b0;
    osd_pixel  = 1'b0;
    clut_wr    = '0;
    pixel_word = 16'h0;
    reset_model();
    rst_n = 1'b0;
    repeat (3) @(negedge clk_114);
    rst_n = 1'b1;
    for (cyc = 0; cyc < run_cycles; cyc++) begin
      drive_inputs();
      #10;                              // Mid low phase, request settled
      check_request();
      @(negedge clk_114);
      step_model();
      check_video();
    end
    if (req_count == 0) begin
      err_other++;
      $display("no pixel requests were seen in any active line");
    end
    if (hic_count == 0 || clut_count == 0) begin
      err_other++;
      $display("hi-colour or palette pixels never reached the output");
    end
    $display("errors: video %0d, request %0d, cadence %0d, other %0d",
             err_vid, err_req, err_cad, err_other);
    if (err_vid + err_req + err_cad + err_other == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // Twice the planned run length
  initial begin
    #(timeout_ns);
    $display("simulation timed out after %0d ns", timeout_ns);
    $display("sim failed");
    $finish;
  end

endmodule

//--- project.f
hw/rtg_pkg.sv
hw/rtg_fetch_timer.sv
hw/rtg_vblank_extend.sv
hw/rtg_clut.sv
hw/rtg_pixel_path.sv
hw/rtg_video_top.sv
testbench/tb_rtg_video.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the RTG mixer testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

top=tb_rtg_video
build_dir=obj_dir
log=sim.log

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --top-module "$top" -Mdir "$build_dir" -o "$top" \
  -f project.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$build_dir/$top" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "sim passed" "$log"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
